// File: design/quickq_pkg.sv
package quickq_pkg;

   ////////////////////
   // widths and depth
   ////////////////////

   // key width, also the Wishbone data width
   localparam int KEY_W = 8;
   // number of key slots
   localparam int DEPTH = 16;
   // RAM index width
   localparam int ADDR_W = 4;
   // count runs 0..DEPTH so one extra bit
   localparam int CNT_W = 5;
   localparam int WB_ADR_W = 2;

   ////////////////////
   // register map
   ////////////////////

   // write only, key to insert
   localparam logic [WB_ADR_W-1:0] REG_ENQ = 2'd0;
   // read only, pops the head
   localparam logic [WB_ADR_W-1:0] REG_DEQ = 2'd1;
   // read only, count and flags
   localparam logic [WB_ADR_W-1:0] REG_STAT = 2'd2;

   // status word layout, count sits in bits 4..0
   localparam int STAT_FULL_BIT = 6;
   localparam int STAT_EMPTY_BIT = 7;

   ////////////////////
   // command and router modes
   ////////////////////

   typedef enum logic [1:0] {
      CMD_ENQ = 2'd0,
      CMD_DEQ = 2'd1
   } cmd_op_e;

   typedef enum logic [2:0] {
      RM_IDLE      = 3'd0,
      RM_ENQ_CMP   = 3'd1,
      RM_ENQ_LAST  = 3'd2,
      RM_DEQ_HEAD  = 3'd3,
      RM_DEQ_SHIFT = 3'd4
   } route_mode_e;

endpackage

// File: design/quickq_cmd_if.sv
`timescale 1ns/1ps
interface quickq_cmd_if;

   // request side, from the bus decoder
   logic                          cmd_valid;
   quickq_pkg::cmd_op_e           cmd_op;
   logic [quickq_pkg::KEY_W-1:0]  cmd_key;

   // completion side, from the sequencer
   logic                          cmd_done;
   // popped key, valid together with cmd_done
   logic [quickq_pkg::KEY_W-1:0]  deq_key;
   // live queue state
   logic [quickq_pkg::CNT_W-1:0]  count;
   logic                          full;
   logic                          empty;

   modport decode (
      output cmd_valid, cmd_op, cmd_key,
      input  cmd_done, deq_key, count, full, empty
   );

   modport execute (
      input  cmd_valid, cmd_op, cmd_key,
      output cmd_done, deq_key, count, full, empty
   );

endinterface

// File: design/quickq_route_if.sv
`timescale 1ns/1ps
interface quickq_route_if;

   // sequencer side
   quickq_pkg::route_mode_e       mode;
   // key travelling down the array during insert
   logic [quickq_pkg::KEY_W-1:0]  carry_key;
   // key just read from the RAM
   logic [quickq_pkg::KEY_W-1:0]  stored_key;
   logic [quickq_pkg::ADDR_W-1:0] idx;
   logic [quickq_pkg::CNT_W-1:0]  count;

   // router side, pure combinational results
   logic                          wr_en;
   logic [quickq_pkg::KEY_W-1:0]  wr_key;
   logic [quickq_pkg::KEY_W-1:0]  next_carry;
   logic [quickq_pkg::CNT_W-1:0]  next_count;
   logic [quickq_pkg::KEY_W-1:0]  out_key;

   modport seq (
      output mode, carry_key, stored_key, idx, count,
      input  wr_en, wr_key, next_carry, next_count, out_key
   );

   modport router (
      input  mode, carry_key, stored_key, idx, count,
      output wr_en, wr_key, next_carry, next_count, out_key
   );

endinterface

// File: design/quickq_wb_decode.sv
`timescale 1ns/1ps
module quickq_wb_decode (
   input  logic                             clk,
   input  logic                             reset_i,
   input  logic                             wb_cyc_i,
   input  logic                             wb_stb_i,
   input  logic                             wb_we_i,
   input  logic [quickq_pkg::WB_ADR_W-1:0]  wb_adr_i,
   input  logic [quickq_pkg::KEY_W-1:0]     wb_dat_i,
   output logic [quickq_pkg::KEY_W-1:0]     wb_dat_o,
   output logic                             wb_ack_o,
   quickq_cmd_if.decode                     cmd
);

   typedef enum logic [1:0] {
      D_IDLE,
      D_BUSY,
      D_ACK,
      D_WAIT
   } dec_state_e;

   dec_state_e                     state;
   logic                           req;
   logic                           is_enq;
   logic                           is_deq;
   logic                           is_stat;
   logic [quickq_pkg::KEY_W-1:0]   stat_word;
   logic [quickq_pkg::KEY_W-1:0]   direct_data;
   logic [quickq_pkg::KEY_W-1:0]   rdata_q;
   logic                           cmd_valid_q;
   quickq_pkg::cmd_op_e            cmd_op_q;
   logic [quickq_pkg::KEY_W-1:0]   cmd_key_q;

   ////////////////////
   // access decode
   ////////////////////

   assign req = wb_cyc_i && wb_stb_i;
   // only these two reach the sequencer, full/empty cases get dropped here
   assign is_enq = wb_we_i && (wb_adr_i == quickq_pkg::REG_ENQ) && !cmd.full;
   assign is_deq = !wb_we_i && (wb_adr_i == quickq_pkg::REG_DEQ) && !cmd.empty;
   assign is_stat = !wb_we_i && (wb_adr_i == quickq_pkg::REG_STAT);

   // status word: empty, full, spare bit, count
   always_comb begin
      stat_word = '0;
      stat_word[quickq_pkg::CNT_W-1:0] = cmd.count;
      stat_word[quickq_pkg::STAT_FULL_BIT] = cmd.full;
      stat_word[quickq_pkg::STAT_EMPTY_BIT] = cmd.empty;
   end

   // anything answered locally reads as 0 unless it is status
   assign direct_data = is_stat ? stat_word : '0;

   ////////////////////
   // handshake FSM
   ////////////////////

   always_ff @(posedge clk) begin
      if (reset_i) begin
         state <= D_IDLE;
         cmd_valid_q <= 1'b0;
         wb_ack_o <= 1'b0;
      end else begin
         // both are single cycle pulses
         cmd_valid_q <= 1'b0;
         wb_ack_o <= 1'b0;
         case (state)
            D_IDLE: begin
               if (req) begin
                  if (is_enq || is_deq) begin
                     cmd_valid_q <= 1'b1;
                     state <= D_BUSY;
                  end else begin
                     state <= D_ACK;
                  end
               end
            end
            // sequencer walking the RAM
            D_BUSY: begin
               if (cmd.cmd_done) begin
                  state <= D_ACK;
               end
            end
            D_ACK: begin
               wb_ack_o <= 1'b1;
               state <= D_WAIT;
            end
            // hold off until the master drops stb
            D_WAIT: begin
               if (!req) begin
                  state <= D_IDLE;
               end
            end
            default: state <= D_IDLE;
         endcase
      end
   end

   // command payload and read data
   always_ff @(posedge clk) begin
      if (state == D_IDLE && req) begin
         cmd_op_q <= wb_we_i ? quickq_pkg::CMD_ENQ : quickq_pkg::CMD_DEQ;
         cmd_key_q <= wb_dat_i;
         rdata_q <= direct_data;
      end else if (state == D_BUSY && cmd.cmd_done) begin
         // enqueue returns nothing
         rdata_q <= (cmd_op_q == quickq_pkg::CMD_DEQ) ? cmd.deq_key : '0;
      end
   end

   assign cmd.cmd_valid = cmd_valid_q;
   assign cmd.cmd_op = cmd_op_q;
   assign cmd.cmd_key = cmd_key_q;
   assign wb_dat_o = rdata_q;

endmodule

// File: design/quickq_key_ram.sv
`timescale 1ns/1ps
module quickq_key_ram (
   input  logic                            clk,
   input  logic [quickq_pkg::ADDR_W-1:0]   addr_i,
   input  logic                            we_i,
   input  logic [quickq_pkg::KEY_W-1:0]    wdata_i,
   output logic [quickq_pkg::KEY_W-1:0]    rdata_o
);

   ////////////////////
   // key storage
   ////////////////////

   // one slot per queue entry, slot 0 is the head
   logic [quickq_pkg::KEY_W-1:0] mem [quickq_pkg::DEPTH];

   // write port
   always_ff @(posedge clk) begin
      if (we_i) begin
         mem[addr_i] <= wdata_i;
      end
   end

   // registered read, data one cycle after the address
   // returns the old word when the same slot is written
   always_ff @(posedge clk) begin
      rdata_o <= mem[addr_i];
   end

endmodule

// File: design/quickq_sequencer.sv
`timescale 1ns/1ps
module quickq_sequencer (
   input  logic                            clk,
   input  logic                            reset_i,
   quickq_cmd_if.execute                   cmd,
   quickq_route_if.seq                     rt,
   output logic [quickq_pkg::ADDR_W-1:0]   ram_addr_o,
   output logic                            ram_we_o,
   output logic [quickq_pkg::KEY_W-1:0]    ram_wdata_o,
   input  logic [quickq_pkg::KEY_W-1:0]    ram_rdata_i
);

   typedef enum logic [2:0] {
      S_IDLE,
      S_ENQ_RD,
      S_ENQ_CMP,
      S_ENQ_LAST,
      S_DEQ_RD0,
      S_DEQ_HEAD,
      S_DEQ_RD,
      S_DEQ_SHIFT
   } seq_state_e;

   seq_state_e                      state;
   logic [quickq_pkg::CNT_W-1:0]    count;
   logic [quickq_pkg::KEY_W-1:0]    carry;
   logic [quickq_pkg::ADDR_W-1:0]   idx;
   logic                            done;
   logic [quickq_pkg::KEY_W-1:0]    deq_key;
   logic                            last_step;

   // idx is the last live slot
   assign last_step = ({1'b0, idx} + 1'b1) == count;

   ////////////////////
   // per phase mode and address
   ////////////////////

   always_comb begin
      rt.mode = quickq_pkg::RM_IDLE;
      ram_addr_o = idx;
      case (state)
         S_ENQ_CMP:   rt.mode = quickq_pkg::RM_ENQ_CMP;
         // idx has reached count here, so this is the tail slot
         S_ENQ_LAST:  rt.mode = quickq_pkg::RM_ENQ_LAST;
         S_DEQ_RD0:   ram_addr_o = '0;
         S_DEQ_HEAD:  rt.mode = quickq_pkg::RM_DEQ_HEAD;
         // fetch the neighbour above, wraps harmlessly on a full queue
         S_DEQ_RD:    ram_addr_o = idx + 1'b1;
         S_DEQ_SHIFT: rt.mode = quickq_pkg::RM_DEQ_SHIFT;
         default:     rt.mode = quickq_pkg::RM_IDLE;
      endcase
   end

   assign rt.carry_key = carry;
   assign rt.stored_key = ram_rdata_i;
   assign rt.idx = idx;
   assign rt.count = count;

   // router decides whether and what gets written
   assign ram_we_o = rt.wr_en;
   assign ram_wdata_o = rt.wr_key;

   ////////////////////
   // control state
   ////////////////////

   always_ff @(posedge clk) begin
      if (reset_i) begin
         state <= S_IDLE;
         count <= '0;
         idx <= '0;
         done <= 1'b0;
      end else begin
         done <= 1'b0;
         case (state)
            S_IDLE: begin
               if (cmd.cmd_valid) begin
                  idx <= '0;
                  if (cmd.cmd_op == quickq_pkg::CMD_ENQ) begin
                     // empty queue goes straight to the tail write
                     state <= (count == '0) ? S_ENQ_LAST : S_ENQ_RD;
                  end else begin
                     state <= S_DEQ_RD0;
                  end
               end
            end
            S_ENQ_RD:   state <= S_ENQ_CMP;
            S_ENQ_CMP: begin
               idx <= idx + 1'b1;
               state <= last_step ? S_ENQ_LAST : S_ENQ_RD;
            end
            S_ENQ_LAST: begin
               count <= rt.next_count;
               done <= 1'b1;
               state <= S_IDLE;
            end
            S_DEQ_RD0:  state <= S_DEQ_HEAD;
            S_DEQ_HEAD: state <= S_DEQ_RD;
            S_DEQ_RD:   state <= S_DEQ_SHIFT;
            S_DEQ_SHIFT: begin
               if (last_step) begin
                  // router drops the count on this step
                  count <= rt.next_count;
                  done <= 1'b1;
                  state <= S_IDLE;
               end else begin
                  idx <= idx + 1'b1;
                  state <= S_DEQ_RD;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   // carried key and popped head
   always_ff @(posedge clk) begin
      if (state == S_IDLE && cmd.cmd_valid) begin
         carry <= cmd.cmd_key;
      end else if (state == S_ENQ_CMP) begin
         carry <= rt.next_carry;
      end
      if (state == S_DEQ_HEAD) begin
         deq_key <= rt.out_key;
      end
   end

   assign cmd.cmd_done = done;
   assign cmd.deq_key = deq_key;
   assign cmd.count = count;
   assign cmd.full = count == quickq_pkg::CNT_W'(quickq_pkg::DEPTH);
   assign cmd.empty = count == '0;

endmodule

// File: design/quickq_value_router.sv
`timescale 1ns/1ps
module quickq_value_router (
   quickq_route_if.router rt
);

   logic [quickq_pkg::CNT_W-1:0] idx_ext;

   // idx widened to count width
   assign idx_ext = {1'b0, rt.idx};

   ////////////////////
   // result select
   ////////////////////

   always_comb begin
      // default: no write, carry and count unchanged
      rt.wr_en = 1'b0;
      rt.wr_key = rt.stored_key;
      rt.next_carry = rt.carry_key;
      rt.next_count = rt.count;
      rt.out_key = '0;
      case (rt.mode)
         quickq_pkg::RM_ENQ_CMP: begin
            // strictly less, so equal keys keep arrival order
            if (rt.carry_key < rt.stored_key) begin
               rt.wr_en = 1'b1;
               rt.wr_key = rt.carry_key;
               rt.next_carry = rt.stored_key;
            end
         end
         quickq_pkg::RM_ENQ_LAST: begin
            // largest key lands at the tail
            rt.wr_en = 1'b1;
            rt.wr_key = rt.carry_key;
            rt.next_count = rt.count + 1'b1;
         end
         quickq_pkg::RM_DEQ_HEAD: begin
            rt.out_key = rt.stored_key;
         end
         quickq_pkg::RM_DEQ_SHIFT: begin
            // stored key came from idx+1, goes to idx
            rt.wr_en = 1'b1;
            rt.wr_key = rt.stored_key;
            if ((idx_ext + 1'b1) == rt.count) begin
               rt.next_count = rt.count - 1'b1;
            end
         end
         default: begin
            rt.wr_en = 1'b0;
         end
      endcase
   end

endmodule

// File: design/quickq_top.sv
`timescale 1ns/1ps
module quickq_top (
   input  logic                             clk,
   input  logic                             reset_i,
   input  logic                             wb_cyc_i,
   input  logic                             wb_stb_i,
   input  logic                             wb_we_i,
   input  logic [quickq_pkg::WB_ADR_W-1:0]  wb_adr_i,
   input  logic [quickq_pkg::KEY_W-1:0]     wb_dat_i,
   output logic [quickq_pkg::KEY_W-1:0]     wb_dat_o,
   output logic                             wb_ack_o
);

   // decode to execute
   quickq_cmd_if   cmd_bus ();
   // execute to router
   quickq_route_if rt_bus ();

   // sequencer to key RAM
   logic [quickq_pkg::ADDR_W-1:0]  ram_addr;
   logic                           ram_we;
   logic [quickq_pkg::KEY_W-1:0]   ram_wdata;
   logic [quickq_pkg::KEY_W-1:0]   ram_rdata;

   ////////////////////
   // bus front end
   ////////////////////

   quickq_wb_decode u_decode (
      .clk      (clk),
      .reset_i  (reset_i),
      .wb_cyc_i (wb_cyc_i),
      .wb_stb_i (wb_stb_i),
      .wb_we_i  (wb_we_i),
      .wb_adr_i (wb_adr_i),
      .wb_dat_i (wb_dat_i),
      .wb_dat_o (wb_dat_o),
      .wb_ack_o (wb_ack_o),
      .cmd      (cmd_bus.decode)
   );

   ////////////////////
   // queue core
   ////////////////////

   quickq_sequencer u_seq (
      .clk         (clk),
      .reset_i     (reset_i),
      .cmd         (cmd_bus.execute),
      .rt          (rt_bus.seq),
      .ram_addr_o  (ram_addr),
      .ram_we_o    (ram_we),
      .ram_wdata_o (ram_wdata),
      .ram_rdata_i (ram_rdata)
   );

   quickq_value_router u_router (
      .rt (rt_bus.router)
   );

   quickq_key_ram u_ram (
      .clk     (clk),
      .addr_i  (ram_addr),
      .we_i    (ram_we),
      .wdata_i (ram_wdata),
      .rdata_o (ram_rdata)
   );

endmodule

// File: tests/quickq_tb.sv
`timescale 1ns/1ps
module quickq_tb;

   // room in the vector array at four bytes per transaction
   localparam int MAX_TRANS = 64;
   localparam int CLK_HALF = 2;
   localparam logic [7:0] OP_END = 8'hff;

   logic                             clk = 1'b0;
   logic                             reset_i = 1'b1;
   logic                             wb_cyc_i = 1'b0;
   logic                             wb_stb_i = 1'b0;
   logic                             wb_we_i = 1'b0;
   logic [quickq_pkg::WB_ADR_W-1:0]  wb_adr_i = '0;
   logic [quickq_pkg::KEY_W-1:0]     wb_dat_i = '0;
   logic [quickq_pkg::KEY_W-1:0]     wb_dat_o;
   logic                             wb_ack_o;

   // op, key, expected read data, check flag
   logic [7:0] vec [4*MAX_TRANS];
   int         n_trans = 0;
   int         ack_seen = 0;
   logic       loaded = 1'b0;
   integer     seed = 32'hf843346e;

   quickq_top u_quickq_top (
      .clk      (clk),
      .reset_i  (reset_i),
      .wb_cyc_i (wb_cyc_i),
      .wb_stb_i (wb_stb_i),
      .wb_we_i  (wb_we_i),
      .wb_adr_i (wb_adr_i),
      .wb_dat_i (wb_dat_i),
      .wb_dat_o (wb_dat_o),
      .wb_ack_o (wb_ack_o)
   );

   // 4 ns clock
   always #CLK_HALF clk = ~clk;

   // every ack cycle counted once
   always @(posedge clk) begin
      if (wb_ack_o) begin
         ack_seen <= ack_seen + 1;
      end
   end

   ////////////////////
   // helpers
   ////////////////////

   task automatic print_failure(input string line);
      $display("%s", line);
      $display("Some tests failed");
   endtask

   // one classic cycle with the request held until ack
   task automatic wb_transfer(input logic [7:0] op, input logic [7:0] key,
                              output logic [7:0] rdata);
      @(posedge clk);
      wb_cyc_i <= 1'b1;
      wb_stb_i <= 1'b1;
      // op bit 4 is the direction and the low bits pick the register
      wb_we_i <= op[4];
      wb_adr_i <= op[1:0];
      wb_dat_i <= key;
      @(posedge clk);
      while (!wb_ack_o) begin
         @(posedge clk);
      end
      rdata = wb_dat_o;
      wb_cyc_i <= 1'b0;
      wb_stb_i <= 1'b0;
      wb_we_i <= 1'b0;
      wb_dat_i <= '0;
      // ack is a single cycle pulse
      @(posedge clk);
      assert (wb_ack_o === 1'b0) else begin
         print_failure($sformatf("ERR wb_ack_o expected %h got %h", 1'b0, wb_ack_o));
         $fatal(1, "ack held longer than one cycle");
      end
   endtask

   task automatic check_read(input int idx, input logic [7:0] expected,
                             input logic [7:0] actual);
      assert (actual === expected) else begin
         print_failure($sformatf("ERR wb_dat_o transaction %0d expected %h got %h",
                                 idx, expected, actual));
         $fatal(1, "read data mismatch");
      end
   endtask

   ////////////////////
   // main sequence
   ////////////////////

   initial begin : stimulus
      logic [7:0] rdata;
      int         gap;
      $readmemh("tests/quickq_testdata.txt", vec);
      // list ends at the first ff op
      while (n_trans < MAX_TRANS && vec[4*n_trans] !== OP_END) begin
         n_trans++;
      end
      loaded = 1'b1;
      repeat (5) @(posedge clk);
      reset_i <= 1'b0;
      for (int i = 0; i < n_trans; i++) begin
         wb_transfer(vec[4*i], vec[4*i+1], rdata);
         if (vec[4*i+3] != 8'h00) begin
            check_read(i, vec[4*i+2], rdata);
         end
         // 0 to 3 idle cycles between transactions
         gap = $random(seed) & 3;
         repeat (gap) @(posedge clk);
      end
      // give a stray ack time to show up
      repeat (4) @(posedge clk);
      assert (ack_seen == n_trans) else begin
         print_failure($sformatf("ERR wb_ack_o count expected %h got %h", n_trans, ack_seen));
         $fatal(1, "ack count mismatch");
      end
      $display("All tests passed");
      $finish;
   end

   ////////////////////
   // watchdog
   ////////////////////

   // generous bound since each transaction walks at most DEPTH entries
   initial begin : watchdog
      wait (loaded);
      repeat (50 * n_trans * (quickq_pkg::DEPTH + 2)) @(posedge clk);
      print_failure("timeout, no ack arrived from the DUT");
      $fatal(1, "watchdog expired");
   end

endmodule

// File: tests/quickq_testdata.txt
// columns: op key expected check, all hex, one transaction per line
// op bit 4 = write, bits 1..0 = register (0 enq, 1 deq, 2 status), ff ends the list
// after reset, empty queue
02 00 80 1
01 00 00 1
00 00 00 1
11 55 00 1
02 00 80 1
// interleaved enqueue and dequeue
10 40 00 0
10 15 00 0
01 00 15 1
10 07 00 0
10 40 00 0
01 00 07 1
10 22 00 0
01 00 22 1
02 00 02 1
12 01 00 1
03 00 00 1
01 00 40 1
01 00 40 1
02 00 80 1
// fill to DEPTH, out of order with duplicates
10 a0 00 0
10 30 00 0
10 c8 00 0
10 05 00 0
10 77 00 0
10 30 00 0
10 e1 00 0
10 12 00 0
02 00 08 1
10 99 00 0
10 5c 00 0
10 05 00 0
10 fe 00 0
10 3b 00 0
10 88 00 0
10 21 00 0
10 6d 00 0
02 00 50 1
// dropped while full
10 01 00 0
02 00 50 1
// drain in ascending order
01 00 05 1
01 00 05 1
01 00 12 1
01 00 21 1
01 00 30 1
01 00 30 1
01 00 3b 1
01 00 5c 1
01 00 6d 1
01 00 77 1
01 00 88 1
01 00 99 1
01 00 a0 1
01 00 c8 1
01 00 e1 1
01 00 fe 1
02 00 80 1
01 00 00 1
02 00 80 1
ff 00 00 0

// File: tb.f
design/quickq_pkg.sv
design/quickq_cmd_if.sv
design/quickq_route_if.sv
design/quickq_wb_decode.sv
design/quickq_key_ram.sv
design/quickq_sequencer.sv
design/quickq_value_router.sv
design/quickq_top.sv
tests/quickq_tb.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module quickq_tb
./obj_dir/Vquickq_tb
